// ==== common/thumb_pkg.sv ====
//////////////////////////////
// Thumb decompressor package
//////////////////////////////

package thumb_pkg;

        //////////////////////////////
        // Widths and word type
        //////////////////////////////

        localparam int THUMB_W = 16;            // Thumb halfword
        localparam int ARM_W   = 32;            // ARM word

        typedef logic [ARM_W-1:0] arm_word_t;

        //////////////////////////////
        // Classified formats
        //////////////////////////////

        typedef enum logic [3:0]
        {
                FMT_ARM         = 4'd0,         // T bit clear, pass through
                FMT_SHIFT       = 4'd1,         // LSL/LSR/ASR immediate
                FMT_ADD_SUB     = 4'd2,         // ADD/SUB low, reg or imm3
                FMT_IMM8        = 4'd3,         // MOV/CMP/ADD/SUB imm8
                FMT_ALU_LO      = 4'd4,         // 16 low register ops
                FMT_ALU_HI      = 4'd5,         // ADD/CMP/MOV high regs
                FMT_B_COND      = 4'd6,
                FMT_B_UNCOND    = 4'd7,
                FMT_SWI         = 4'd8,
                FMT_UND         = 4'd9          // Anything not kept
        } thumb_fmt_e;

        //////////////////////////////
        // ARM data processing fields
        //////////////////////////////

        typedef enum logic [3:0]
        {
                OP_AND = 4'd0,
                OP_EOR = 4'd1,
                OP_SUB = 4'd2,
                OP_RSB = 4'd3,
                OP_ADD = 4'd4,
                OP_ADC = 4'd5,
                OP_SBC = 4'd6,
                OP_TST = 4'd8,
                OP_CMP = 4'd10,
                OP_CMN = 4'd11,
                OP_ORR = 4'd12,
                OP_MOV = 4'd13,
                OP_BIC = 4'd14,
                OP_MVN = 4'd15
        } dp_op_e;

        typedef enum logic [1:0]
        {
                SH_LSL = 2'd0,
                SH_LSR = 2'd1,
                SH_ASR = 2'd2,
                SH_ROR = 2'd3
        } shift_e;

        localparam logic [3:0] COND_AL = 4'b1110;       // Always execute

        // Fixed bits of SWI and B, cond field left at zero
        localparam arm_word_t ARM_SWI_BASE = 32'h0F00_0000;
        localparam arm_word_t ARM_B_BASE   = 32'h0A00_0000;    // L bit clear

        //////////////////////////////
        // Thumb match patterns
        //////////////////////////////

        localparam logic [THUMB_W-1:0] PAT_SWI      = 16'b1101_1111_????_????;
        localparam logic [THUMB_W-1:0] PAT_ADD_SUB  = 16'b0001_1???_????_????;
        localparam logic [THUMB_W-1:0] PAT_B_COND   = 16'b1101_????_????_????;
        localparam logic [THUMB_W-1:0] PAT_B_UNCOND = 16'b1110_0???_????_????;
        localparam logic [THUMB_W-1:0] PAT_SHIFT    = 16'b000?_????_????_????;
        localparam logic [THUMB_W-1:0] PAT_IMM8     = 16'b001?_????_????_????;
        localparam logic [THUMB_W-1:0] PAT_ALU_LO   = 16'b0100_00??_????_????;
        localparam logic [THUMB_W-1:0] PAT_ALU_HI   = 16'b0100_01??_????_????;

endpackage

// ==== common/expand_if.sv ====
//////////////////////////////
// Classified halfword bus
//////////////////////////////

`timescale 1ns/1ps

interface expand_if
        import thumb_pkg::*;
();

        logic                   valid;          // Input qualifier
        thumb_fmt_e             fmt;            // Decoded format
        logic [THUMB_W-1:0]     halfword;       // Low half of input
        arm_word_t              arm_in;         // Full word for ARM state

        modport classify (output valid, output fmt, output halfword, output arm_in);

        // Expanders see only the fields
        modport expand (input fmt, input halfword);

        modport result (input valid, input fmt, input arm_in);

endinterface

// ==== design/decode/thumb_classify.sv ====
//////////////////////////////
// Thumb format classifier
//////////////////////////////

`timescale 1ns/1ps

module thumb_classify
        import thumb_pkg::*;
(
        input  arm_word_t       i_instruction,
        input  logic            i_instruction_valid,
        input  logic            i_cpsr_t,
        expand_if.classify      ex
);

        logic [THUMB_W-1:0] hw;         // Halfword under decode

        assign hw = i_instruction[THUMB_W-1:0];

        // Payload goes straight through
        assign ex.valid    = i_instruction_valid;
        assign ex.halfword = hw;
        assign ex.arm_in   = i_instruction;

        //////////////////////////////
        // Pattern match
        //////////////////////////////

        always_comb
        begin
                ex.fmt = FMT_UND;

                if (!i_cpsr_t)
                begin
                        ex.fmt = FMT_ARM;               // ARM state
                end
                else if (hw ==? PAT_SWI)                // Overlaps cond branch
                begin
                        ex.fmt = FMT_SWI;
                end
                else if (hw ==? PAT_ADD_SUB)            // Overlaps shift
                begin
                        ex.fmt = FMT_ADD_SUB;
                end
                else
                begin
                        casez (hw)
                        PAT_B_COND   : ex.fmt = FMT_B_COND;
                        PAT_B_UNCOND : ex.fmt = FMT_B_UNCOND;
                        PAT_SHIFT    : ex.fmt = FMT_SHIFT;
                        PAT_IMM8     : ex.fmt = FMT_IMM8;
                        PAT_ALU_LO   : ex.fmt = FMT_ALU_LO;
                        PAT_ALU_HI   :
                        begin
                                // Op 3 was BX/BLX, not supported here
                                if (hw[9:8] == 2'd3)
                                        ex.fmt = FMT_UND;
                                else
                                        ex.fmt = FMT_ALU_HI;
                        end
                        default      : ex.fmt = FMT_UND;   // Loads, stores, BL
                        endcase
                end
        end

endmodule

// ==== design/expand/dp_expand.sv ====
//////////////////////////////
// Data processing expander
//////////////////////////////

`timescale 1ns/1ps

module dp_expand
        import thumb_pkg::*;
(
        expand_if.expand        ex,
        output arm_word_t       o_dp_word
);

        logic [THUMB_W-1:0] hw;
        logic [3:0]         rd_lo;      // Bits 2:0
        logic [3:0]         rs_lo;      // Bits 5:3
        logic [3:0]         rn_lo;      // Bits 8:6, reg or imm3
        logic [3:0]         rd_i8;      // Bits 10:8 of imm8 form
        logic [3:0]         rd_hi;      // H1 and bits 2:0
        logic [3:0]         rs_hi;      // H2 and bits 5:3
        logic [3:0]         alu_op;
        logic [1:0]         hi_op;

        assign hw     = ex.halfword;
        assign rd_lo  = {1'b0, hw[2:0]};
        assign rs_lo  = {1'b0, hw[5:3]};
        assign rn_lo  = {1'b0, hw[8:6]};
        assign rd_i8  = {1'b0, hw[10:8]};
        assign rd_hi  = {hw[7], hw[2:0]};
        assign rs_hi  = {hw[6], hw[5:3]};
        assign alu_op = hw[9:6];
        assign hi_op  = hw[9:8];

        // Always condition, data processing class
        function automatic arm_word_t dp(
                input logic       imm,
                input dp_op_e     op,
                input logic       s,
                input logic [3:0] rn,
                input logic [3:0] rd,
                input logic [11:0] op2
        );
                return {COND_AL, 2'b00, imm, op, s, rn, rd, op2};
        endfunction

        //////////////////////////////
        // Word forming
        //////////////////////////////

        always_comb
        begin
                o_dp_word = '0;

                case (ex.fmt)
                FMT_SHIFT:
                begin
                        // MOVS Rd, Rs, <type> #imm5
                        o_dp_word = dp(1'b0, OP_MOV, 1'b1, 4'd0, rd_lo,
                                       {hw[10:6], hw[12:11], 1'b0, rs_lo});
                end
                FMT_ADD_SUB:
                begin
                        case ({hw[9], hw[10]})  // Sub, imm
                        2'd0: o_dp_word = dp(1'b0, OP_ADD, 1'b1, rs_lo, rd_lo, {8'd0, rn_lo});
                        2'd1: o_dp_word = dp(1'b1, OP_ADD, 1'b1, rs_lo, rd_lo, {8'd0, rn_lo});
                        2'd2: o_dp_word = dp(1'b0, OP_SUB, 1'b1, rs_lo, rd_lo, {8'd0, rn_lo});
                        default: o_dp_word = dp(1'b1, OP_SUB, 1'b1, rs_lo, rd_lo, {8'd0, rn_lo});
                        endcase
                end
                FMT_IMM8:
                begin
                        case (hw[12:11])
                        2'd0: o_dp_word = dp(1'b1, OP_MOV, 1'b1, rd_i8, rd_i8, {4'd0, hw[7:0]});
                        2'd1: o_dp_word = dp(1'b1, OP_CMP, 1'b1, rd_i8, rd_i8, {4'd0, hw[7:0]});
                        2'd2: o_dp_word = dp(1'b1, OP_ADD, 1'b1, rd_i8, rd_i8, {4'd0, hw[7:0]});
                        default: o_dp_word = dp(1'b1, OP_SUB, 1'b1, rd_i8, rd_i8, {4'd0, hw[7:0]});
                        endcase
                end
                FMT_ALU_LO:
                begin
                        case (alu_op)
                        // Register specified shifts, MOVS Rd, Rd, <type> Rs
                        4'd2: o_dp_word = dp(1'b0, OP_MOV, 1'b1, rd_lo, rd_lo,
                                             {rs_lo, 1'b0, SH_LSL, 1'b1, rd_lo});
                        4'd3: o_dp_word = dp(1'b0, OP_MOV, 1'b1, rd_lo, rd_lo,
                                             {rs_lo, 1'b0, SH_LSR, 1'b1, rd_lo});
                        4'd4: o_dp_word = dp(1'b0, OP_MOV, 1'b1, rd_lo, rd_lo,
                                             {rs_lo, 1'b0, SH_ASR, 1'b1, rd_lo});
                        4'd7: o_dp_word = dp(1'b0, OP_MOV, 1'b1, rd_lo, rd_lo,
                                             {rs_lo, 1'b0, SH_ROR, 1'b1, rd_lo});
                        4'd9:
                        begin
                                // NEG is RSBS Rd, Rs, #0
                                o_dp_word = dp(1'b1, OP_RSB, 1'b1, rs_lo, rd_lo, 12'd0);
                        end
                        4'd13:
                        begin
                                // MULS Rd, Rs, Rd
                                o_dp_word = {COND_AL, 7'b0000000, 1'b1, rd_lo, 4'd0,
                                             rd_lo, 4'b1001, rs_lo};
                        end
                        default:
                        begin
                                // Remaining Thumb op numbers equal the ARM opcodes
                                o_dp_word = dp(1'b0, dp_op_e'(alu_op), 1'b1, rd_lo, rd_lo,
                                               {8'd0, rs_lo});
                        end
                        endcase
                end
                FMT_ALU_HI:
                begin
                        case (hi_op)
                        2'd0: o_dp_word = dp(1'b0, OP_ADD, 1'b0, rd_hi, rd_hi, {8'd0, rs_hi});
                        2'd1: o_dp_word = dp(1'b0, OP_CMP, 1'b1, rd_hi, rd_hi, {8'd0, rs_hi});
                        2'd2: o_dp_word = dp(1'b0, OP_MOV, 1'b0, rd_hi, rd_hi, {8'd0, rs_hi});
                        default: o_dp_word = '0;        // Classified as UND
                        endcase
                end
                default:
                begin
                        o_dp_word = '0;                 // Not a data format
                end
                endcase
        end

endmodule

// ==== design/expand/branch_expand.sv ====
//////////////////////////////
// Branch and SWI expander
//////////////////////////////

`timescale 1ns/1ps

module branch_expand
        import thumb_pkg::*;
(
        expand_if.expand        ex,
        output arm_word_t       o_br_word
);

        logic [THUMB_W-1:0] hw;
        logic [23:0]        off_cond;           // Sign extended imm8
        logic [23:0]        off_uncond;         // Sign extended imm11

        assign hw         = ex.halfword;
        assign off_cond   = {{16{hw[7]}}, hw[7:0]};
        assign off_uncond = {{13{hw[10]}}, hw[10:0]};

        // Offsets stay in halfword units, shifted downstream
        always_comb
        begin
                o_br_word = '0;

                case (ex.fmt)
                FMT_B_COND:
                begin
                        o_br_word = {hw[11:8], ARM_B_BASE[27:24], off_cond};    // Thumb cond
                end
                FMT_B_UNCOND:
                begin
                        o_br_word = {COND_AL, ARM_B_BASE[27:24], off_uncond};
                end
                FMT_SWI:
                begin
                        // Comment field in low byte only
                        o_br_word = {COND_AL, ARM_SWI_BASE[27:8], hw[7:0]};
                end
                default:
                begin
                        o_br_word = '0;
                end
                endcase
        end

endmodule

// ==== design/thumb_result.sv ====
//////////////////////////////
// Output select and register
//////////////////////////////

`timescale 1ns/1ps

module thumb_result
        import thumb_pkg::*;
(
        input  logic            i_clk,
        input  logic            i_rst_n,
        expand_if.result        ex,
        input  arm_word_t       i_dp_word,
        input  arm_word_t       i_br_word,
        output arm_word_t       o_instruction,
        output logic            o_valid,
        output logic            o_und,
        output logic            o_half_shift
);

        arm_word_t word_nxt;
        logic      und_nxt;
        logic      half_nxt;

        //////////////////////////////
        // Select by format
        //////////////////////////////

        always_comb
        begin
                word_nxt = '0;
                und_nxt  = 1'b0;
                half_nxt = 1'b0;

                case (ex.fmt)
                FMT_ARM      : word_nxt = ex.arm_in;            // Untouched
                FMT_B_COND,
                FMT_B_UNCOND :
                begin
                        word_nxt = i_br_word;
                        half_nxt = 1'b1;                        // Offset in halfwords
                end
                FMT_SWI      : word_nxt = i_br_word;
                FMT_UND      : und_nxt  = 1'b1;                 // Word stays zero
                default      : word_nxt = i_dp_word;            // Data formats
                endcase

                // Nothing leaks out without valid
                if (!ex.valid)
                begin
                        word_nxt = '0;
                        und_nxt  = 1'b0;
                        half_nxt = 1'b0;
                end
        end

        // Single pipeline stage
        always_ff @(posedge i_clk)
        begin
                if (!i_rst_n)
                begin
                        o_instruction <= '0;
                        o_valid       <= 1'b0;
                        o_und         <= 1'b0;
                        o_half_shift  <= 1'b0;
                end
                else
                begin
                        o_instruction <= word_nxt;
                        o_valid       <= ex.valid;
                        o_und         <= und_nxt;
                        o_half_shift  <= half_nxt;
                end
        end

endmodule

// ==== design/thumb_decompress.sv ====
//////////////////////////////
// Thumb decompressor top
//////////////////////////////

`timescale 1ns/1ps

module thumb_decompress
        import thumb_pkg::*;
(
        input  logic            i_clk,
        input  logic            i_rst_n,

        // Fetched word and state
        input  arm_word_t       i_instruction,
        input  logic            i_instruction_valid,
        input  logic            i_cpsr_t,               // Thumb state

        // To ARM decode, one cycle later
        output arm_word_t       o_instruction,
        output logic            o_valid,
        output logic            o_und,
        output logic            o_half_shift            // Offset in halfwords
);

        expand_if ex_bus ();

        arm_word_t dp_word;                             // Data processing form
        arm_word_t br_word;                             // Branch / SWI form

        thumb_classify u_classify (
                .i_instruction          (i_instruction),
                .i_instruction_valid    (i_instruction_valid),
                .i_cpsr_t               (i_cpsr_t),
                .ex                     (ex_bus.classify)
        );

        dp_expand u_dp_expand (
                .ex                     (ex_bus.expand),
                .o_dp_word              (dp_word)
        );

        branch_expand u_branch_expand (
                .ex                     (ex_bus.expand),
                .o_br_word              (br_word)
        );

        thumb_result u_result (
                .i_clk                  (i_clk),
                .i_rst_n                (i_rst_n),
                .ex                     (ex_bus.result),
                .i_dp_word              (dp_word),
                .i_br_word              (br_word),
                .o_instruction          (o_instruction),
                .o_valid                (o_valid),
                .o_und                  (o_und),
                .o_half_shift           (o_half_shift)
        );

endmodule

// ==== test/thumb_model.svh ====
//////////////////////////////
// Decompressor reference model
//////////////////////////////

`ifndef THUMB_MODEL_SVH
`define THUMB_MODEL_SVH

// ARM data processing word, condition always
function automatic logic [31:0] pack_dp(
        input logic        imm_bit,
        input logic [3:0]  opcode,
        input logic        set_flags,
        input logic [3:0]  rn,
        input logic [3:0]  rd,
        input logic [11:0] op2
);
        logic [31:0] w;

        w        = 32'hE000_0000;
        w[25]    = imm_bit;
        w[24:21] = opcode;
        w[20]    = set_flags;
        w[19:16] = rn;
        w[15:12] = rd;
        w[11:0]  = op2;
        return w;
endfunction

// Expected {valid, und, half_shift, word} for one input
function automatic logic [34:0] model_expand(
        input logic [31:0] instr,
        input logic        valid,
        input logic        t_bit
);
        logic [15:0] hw;
        logic [31:0] word;
        logic        und;
        logic        half;
        logic [3:0]  rd;
        logic [3:0]  rs;
        logic [3:0]  rdh;
        logic [3:0]  rsh;
        logic [3:0]  op;
        logic [1:0]  sh_type;

        hw   = instr[15:0];
        word = 32'd0;
        und  = 1'b0;
        half = 1'b0;
        rd   = {1'b0, hw[2:0]};
        rs   = {1'b0, hw[5:3]};
        rdh  = {hw[7], hw[2:0]};
        rsh  = {hw[6], hw[5:3]};
        op   = hw[9:6];

        if (!t_bit)
                word = instr;                           // ARM state
        else if (hw[15:8] == 8'hDF)
                word = 32'hEF00_0000 | {24'd0, hw[7:0]};        // SWI
        else if (hw[15:11] == 5'b00011)
                word = pack_dp(hw[10], hw[9] ? 4'd2 : 4'd4, 1'b1, rs, rd, {9'd0, hw[8:6]});
        else if (hw[15:12] == 4'hD)
        begin
                word = {hw[11:8], 4'hA, {16{hw[7]}}, hw[7:0]};
                half = 1'b1;
        end
        else if (hw[15:11] == 5'b11100)
        begin
                word = {8'hEA, {13{hw[10]}}, hw[10:0]};
                half = 1'b1;
        end
        else if (hw[15:13] == 3'b000)                   // MOVS imm shift
                word = pack_dp(1'b0, 4'd13, 1'b1, 4'd0, rd, {hw[10:6], hw[12:11], 2'b00, hw[5:3]});
        else if (hw[15:13] == 3'b001)
        begin
                case (hw[12:11])
                2'd0:    op = 4'd13;                    // MOV
                2'd1:    op = 4'd10;                    // CMP
                2'd2:    op = 4'd4;                     // ADD
                default: op = 4'd2;                     // SUB
                endcase
                word = pack_dp(1'b1, op, 1'b1, {1'b0, hw[10:8]}, {1'b0, hw[10:8]},
                               {4'd0, hw[7:0]});
        end
        else if (hw[15:10] == 6'b010000)
        begin
                case (op)
                4'd2, 4'd3, 4'd4, 4'd7:
                begin
                        sh_type = (op == 4'd2) ? 2'd0 : (op == 4'd3) ? 2'd1 :
                                  (op == 4'd4) ? 2'd2 : 2'd3;
                        word = pack_dp(1'b0, 4'd13, 1'b1, rd, rd, {rs, 1'b0, sh_type, 1'b1, rd});
                end
                4'd9:    word = pack_dp(1'b1, 4'd3, 1'b1, rs, rd, 12'd0);    // NEG
                4'd13:
                begin
                        word        = 32'hE010_0090;    // MULS
                        word[19:16] = rd;
                        word[11:8]  = rd;
                        word[3:0]   = rs;
                end
                default: word = pack_dp(1'b0, op, 1'b1, rd, rd, {8'd0, rs});
                endcase
        end
        else if (hw[15:10] == 6'b010001)
        begin
                case (hw[9:8])
                2'd0:    word = pack_dp(1'b0, 4'd4, 1'b0, rdh, rdh, {8'd0, rsh});
                2'd1:    word = pack_dp(1'b0, 4'd10, 1'b1, rdh, rdh, {8'd0, rsh});
                2'd2:    word = pack_dp(1'b0, 4'd13, 1'b0, rdh, rdh, {8'd0, rsh});
                default: und = 1'b1;                    // BX slot
                endcase
        end
        else
                und = 1'b1;

        if (!valid)
                return 35'd0;
        return {1'b1, und, half, word};
endfunction

`endif

// ==== test/tb_thumb_decompress.sv ====
//////////////////////////////
// Thumb decompressor testbench
//////////////////////////////

`timescale 1ns/1ps

module tb_thumb_decompress;

        localparam int  HALF_PERIOD  = 20;              // 40 ns clock
        localparam int  RESET_CYCLES = 5;
        localparam int  WAIT_LIMIT   = 20;              // Cycles per wait loop
        localparam time RUN_LIMIT    = 200us;

        logic        i_clk = 1'b0;
        logic        i_rst_n;
        logic [31:0] i_instruction;
        logic        i_instruction_valid;
        logic        i_cpsr_t;
        logic [31:0] o_instruction;
        logic        o_valid;
        logic        o_und;
        logic        o_half_shift;

        logic [31:0] lcg_state = 32'd95948;
        int          cycle_count = 0;
        logic [34:0] exp_q[$];                          // {valid, und, half, word}
        int          due_q[$];                          // Cycle each result is due
        string       test_name;
        int          test_checks;
        int          test_errors;
        int          total_checks = 0;
        int          total_errors = 0;
        int          tests_run = 0;
        int          tests_failed = 0;

        `include "thumb_model.svh"

        thumb_decompress dut0 (
                .i_clk                  (i_clk),
                .i_rst_n                (i_rst_n),
                .i_instruction          (i_instruction),
                .i_instruction_valid    (i_instruction_valid),
                .i_cpsr_t               (i_cpsr_t),
                .o_instruction          (o_instruction),
                .o_valid                (o_valid),
                .o_und                  (o_und),
                .o_half_shift           (o_half_shift)
        );

        always #HALF_PERIOD i_clk = ~i_clk;

        always @(posedge i_clk)
                cycle_count <= cycle_count + 1;         // Capture edges seen

        // Global guard against a stuck run
        initial
        begin
                #RUN_LIMIT;
                $display("timeout: simulation ran past its time limit");
                $display("SOME TESTS FAILED");
                $finish;
        end

        //////////////////////////////
        // Helpers
        //////////////////////////////

        function automatic logic [15:0] next_random();
                lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
                return lcg_state[31:16];                // Upper bits, better period
        endfunction

        task automatic report_mismatch(input string field, input logic [31:0] exp,
                                       input logic [31:0] act);
                $display("FAIL %s %s expected %08h actual %08h", test_name, field, exp, act);
                test_errors++;
        endtask

        task automatic compare_outputs(input logic [34:0] exp);
                test_checks++;
                assert (o_valid === exp[34])
                else report_mismatch("o_valid", {31'd0, exp[34]}, {31'd0, o_valid});
                assert (o_und === exp[33])
                else report_mismatch("o_und", {31'd0, exp[33]}, {31'd0, o_und});
                assert (o_half_shift === exp[32])
                else report_mismatch("o_half_shift", {31'd0, exp[32]}, {31'd0, o_half_shift});
                assert (o_instruction === exp[31:0])
                else report_mismatch("o_instruction", exp[31:0], o_instruction);
        endtask

        // Compare every result whose capture edge has passed
        task automatic check_due();
                while (due_q.size() > 0 && due_q[0] <= cycle_count)
                begin
                        compare_outputs(exp_q.pop_front());
                        void'(due_q.pop_front());
                end
        endtask

        task automatic drive_word(input logic [31:0] instr, input logic valid,
                                  input logic t_bit);
                @(negedge i_clk);
                check_due();
                i_instruction       = instr;
                i_instruction_valid = valid;
                i_cpsr_t            = t_bit;
                exp_q.push_back(model_expand(instr, valid, t_bit));
                due_q.push_back(cycle_count + 1);       // One stage later
        endtask

        task automatic drain_pipeline();
                int guard;

                guard = 0;
                while (exp_q.size() > 0 && guard < WAIT_LIMIT)
                begin
                        @(negedge i_clk);
                        check_due();
                        guard++;
                end
                if (exp_q.size() > 0)
                begin
                        $display("timeout: %s results never came out of the DUT", test_name);
                        $display("SOME TESTS FAILED");
                        $finish;
                end
        endtask

        task automatic start_test(input string name);
                test_name   = name;
                test_checks = 0;
                test_errors = 0;
        endtask

        task automatic finish_test();
                drain_pipeline();
                $display("%s: %0d checks, %0d errors", test_name, test_checks, test_errors);
                tests_run++;
                total_checks += test_checks;
                total_errors += test_errors;
                if (test_errors > 0)
                        tests_failed++;
        endtask

        //////////////////////////////
        // Test sequence
        //////////////////////////////

        initial
        begin
                int          i;
                int          sel;
                int          guard;
                logic [15:0] r;
                logic [15:0] hw;

                i_rst_n             = 1'b0;
                i_instruction       = 32'd0;
                i_instruction_valid = 1'b0;
                i_cpsr_t            = 1'b0;

                // Outputs must stay clear while reset is held
                start_test("reset_and_valid");
                guard = 0;
                while (cycle_count < RESET_CYCLES && guard < WAIT_LIMIT)
                begin
                        @(negedge i_clk);
                        compare_outputs(35'd0);
                        i_instruction       = {next_random(), next_random()};
                        i_instruction_valid = 1'b1;     // Live words, reset must win
                        i_cpsr_t            = guard[0];
                        guard++;
                end
                if (cycle_count < RESET_CYCLES)
                begin
                        $display("timeout: reset cycles never completed");
                        $display("SOME TESTS FAILED");
                        $finish;
                end
                i_instruction_valid = 1'b0;
                i_rst_n = 1'b1;
                for (i = 0; i < 12; i++)
                        drive_word({next_random(), next_random()}, 1'b0,
                                   1'(next_random() % 2));
                finish_test();

                start_test("arm_pass_through");
                for (i = 0; i < 40; i++)
                        drive_word({next_random(), next_random()}, 1'b1, 1'b0);
                finish_test();

                start_test("shift_addsub_imm8");
                for (i = 0; i < 60; i++)
                begin
                        r   = next_random();
                        sel = next_random() % 3;
                        if (sel == 0)
                                hw = {3'b000, 2'(next_random() % 3), r[10:0]};  // No op 3
                        else if (sel == 1)
                                hw = {5'b00011, r[10:0]};
                        else
                                hw = {3'b001, r[12:0]};
                        drive_word({next_random(), hw}, 1'b1, 1'b1);
                end
                finish_test();

                start_test("alu_low_high");
                for (i = 0; i < 48; i++)
                        drive_word({next_random(), 6'b010000, 4'(i % 16), 6'(next_random() % 64)},
                                   1'b1, 1'b1);
                for (i = 0; i < 16; i++)
                        drive_word({next_random(), 6'b010001, 2'(i % 4), 8'(next_random())},
                                   1'b1, 1'b1);
                finish_test();

                start_test("branch_swi");
                for (i = 0; i < 45; i++)
                begin
                        r   = next_random();
                        sel = i % 3;
                        if (sel == 0)                   // Alternate offset sign
                                hw = {4'hD, 4'(next_random() % 14), i[1], r[6:0]};
                        else if (sel == 1)
                                hw = {5'b11100, i[2], r[9:0]};
                        else
                                hw = {8'hDF, r[7:0]};
                        drive_word({next_random(), hw}, 1'b1, 1'b1);
                end
                finish_test();

                start_test("dropped_formats");
                for (i = 0; i < 48; i++)
                begin
                        r = next_random();
                        case (next_random() % 12)
                        0:       hw = {4'h5, r[11:0]};          // Register load/store
                        1:       hw = {4'h6, r[11:0]};          // Word immediate
                        2:       hw = {4'h7, r[11:0]};          // Byte immediate
                        3:       hw = {4'h8, r[11:0]};          // Halfword
                        4:       hw = {4'h9, r[11:0]};          // SP relative
                        5:       hw = {4'hA, r[11:0]};          // ADD to PC/SP
                        6:       hw = {4'hB, r[11:0]};          // PUSH/POP, SP adjust
                        7:       hw = {4'hC, r[11:0]};          // LDM/STM
                        8:       hw = {4'hF, r[11:0]};          // BL
                        9:       hw = {5'b11101, r[10:0]};      // BLX suffix
                        10:      hw = {5'b01001, r[10:0]};      // PC relative load
                        default: hw = {8'b01000111, r[7:0]};    // BX/BLX
                        endcase
                        drive_word({next_random(), hw}, 1'b1, 1'b1);
                end
                finish_test();

                $display("tests %0d, failed %0d, checks %0d, errors %0d",
                         tests_run, tests_failed, total_checks, total_errors);
                if (tests_failed == 0 && total_errors == 0)
                begin
                        $display("ALL TESTS PASSED");
                end
                else
                begin
                        $display("SOME TESTS FAILED");
                end
                $finish;
        end

endmodule

// ==== build.f ====
+incdir+test
common/thumb_pkg.sv
common/expand_if.sv
design/decode/thumb_classify.sv
design/expand/dp_expand.sv
design/expand/branch_expand.sv
design/thumb_result.sv
design/thumb_decompress.sv
test/tb_thumb_decompress.sv
